// ==== verilog/mem_pkg.sv ====
package mem_pkg;

  // ---------------------------------------------------------------------
  // SRAM geometry
  // ---------------------------------------------------------------------

  // Same depth and width for input, weights and output memories
  localparam int addr_w = 12;
  localparam int data_w = 16;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // ---------------------------------------------------------------------
  // Input SRAM word views
  // ---------------------------------------------------------------------

  // Word 0 of the input memory
  // Image size sits in the low byte
  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] size;
  } in_hdr_s;

  // Image words carry two pixels
  // Even column in the high byte
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } in_pix_s;

  // Same bits read as header or as pixel pair
  typedef union packed {
    in_hdr_s hdr;
    in_pix_s pix;
  } in_word_u;

  // Output SRAM write port
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } out_wr_s;

endpackage

// ==== verilog/cnn_pkg.sv ====
package cnn_pkg;

  // ---------------------------------------------------------------------
  // Arithmetic types
  // ---------------------------------------------------------------------

  // int8 pixels and weights
  typedef logic signed [7:0] pixel_t;

  // Nine products of two int8 values fit easily
  localparam int acc_w = 20;
  typedef logic signed [acc_w-1:0] acc_t;

  // ReLU upper clamp
  localparam int relu_max = 127;

  // Largest supported image edge and width of a size register
  localparam int max_n  = 64;
  localparam int size_w = $clog2(max_n + 1);

  // Weight SRAM words holding the 3x3 kernel
  localparam int weight_words = 5;

  // ---------------------------------------------------------------------
  // Kernel bank and lane interface
  // ---------------------------------------------------------------------

  // Row-major 3x3 kernel
  typedef struct packed {
    pixel_t w00;
    pixel_t w01;
    pixel_t w02;
    pixel_t w10;
    pixel_t w11;
    pixel_t w12;
    pixel_t w20;
    pixel_t w21;
    pixel_t w22;
  } kernel_s;

  // One step per returned image word
  // half picks left or right word of the row
  typedef struct packed {
    logic       valid;
    logic [1:0] krow;
    logic       half;
    logic       first;
    logic       last;
  } lane_step_s;

  // Clamped results of one conv row pair
  typedef struct packed {
    logic       valid;
    logic [7:0] left;
    logic [7:0] right;
  } lane_res_s;

endpackage

// ==== verilog/conv_ctrl.sv ====
`timescale 1ns/1ps

module conv_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                dut_run,
  input  mem_pkg::in_word_u   in_rd_data,
  input  mem_pkg::data_t      wt_rd_data,
  input  logic                done,
  output mem_pkg::addr_t      in_rd_addr,
  output mem_pkg::addr_t      wt_rd_addr,
  output cnn_pkg::kernel_s    kernel,
  output cnn_pkg::lane_step_s step_up,
  output cnn_pkg::lane_step_s step_lo,
  output logic                blocks_done,
  output logic                dut_busy
);

  typedef enum logic [2:0] {
    st_idle,
    st_wgt,
    st_hdr,
    st_conv,
    st_drain
  } state_t;

  state_t state;

  // Weight read index
  logic [2:0] wcnt;
  // Flags lined up with returned SRAM data
  logic       wld_q;
  logic       wlast_q;
  logic       hdr_q;

  // Image edge and words per row
  logic [cnn_pkg::size_w-1:0] n_size;
  logic [cnn_pkg::size_w-2:0] half_n;

  // Block walk state
  logic [2:0]                 phase;
  logic [cnn_pkg::size_w-2:0] cw;
  logic [cnn_pkg::size_w-1:0] brow;
  mem_pkg::addr_t             row_base;
  mem_pkg::addr_t             row_off;
  logic                       in_conv;
  logic                       wgt_end;
  logic                       last_col;
  logic                       last_blk;

  // Step for a pass over krow 0..2 with both words per row
  function automatic cnn_pkg::lane_step_s make_step(input logic on, input logic [2:0] p);
    cnn_pkg::lane_step_s s;
    s.valid = on;
    s.krow  = p[2:1];
    s.half  = p[0];
    s.first = on && (p == 3'd0);
    s.last  = on && (p == 3'd5);
    return s;
  endfunction

  assign half_n   = n_size[cnn_pkg::size_w-1:1];
  assign in_conv  = (state == st_conv);
  assign dut_busy = (state != st_idle);
  assign wgt_end  = (wcnt == 3'(cnn_pkg::weight_words - 1));

  // Last block column is word N/2-2
  assign last_col = (cw + 2'd2 == half_n);
  assign last_blk = last_col && (brow + 3'd4 == n_size);

  // ---------------------------------------------------------------------
  // Read addresses
  // ---------------------------------------------------------------------

  // Phase bits 2:1 pick the row inside the block and bit 0 the word
  assign row_off = mem_pkg::addr_t'(phase[2:1]) * mem_pkg::addr_t'(half_n);

  // Header read at address 0
  assign in_rd_addr = in_conv ?
                      row_base + mem_pkg::addr_t'(cw) + row_off + mem_pkg::addr_t'(phase[0]) :
                      '0;

  assign wt_rd_addr = mem_pkg::addr_t'(wcnt);

  // ---------------------------------------------------------------------
  // Job FSM and block walk
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      wcnt     <= '0;
      phase    <= '0;
      cw       <= '0;
      brow     <= '0;
      row_base <= '0;
    end else begin
      case (state)
        st_idle: begin
          wcnt <= '0;
          // Runs while busy never reach here
          if (dut_run) begin
            state <= st_wgt;
          end
        end
        st_wgt: begin
          wcnt <= wcnt + 1'b1;
          if (wgt_end) begin
            state <= st_hdr;
          end
        end
        st_hdr: begin
          state    <= st_conv;
          phase    <= '0;
          cw       <= '0;
          brow     <= '0;
          // Image data starts after the header word
          row_base <= mem_pkg::addr_t'(1);
        end
        st_conv: begin
          phase <= phase + 1'b1;
          if (phase == 3'd7) begin
            if (last_blk) begin
              state <= st_drain;
            end else if (last_col) begin
              // Next block row is two image rows down
              cw       <= '0;
              brow     <= brow + 2'd2;
              row_base <= row_base + mem_pkg::addr_t'(n_size);
            end else begin
              cw <= cw + 1'b1;
            end
          end
        end
        st_drain: begin
          // Wait for the last pooled word
          if (done) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Returned data capture
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wld_q   <= 1'b0;
      wlast_q <= 1'b0;
      hdr_q   <= 1'b0;
      n_size  <= '0;
    end else begin
      wld_q   <= (state == st_wgt);
      wlast_q <= (state == st_wgt) && wgt_end;
      hdr_q   <= (state == st_hdr);
      if (hdr_q) begin
        n_size <= in_rd_data.hdr.size[cnn_pkg::size_w-1:0];
      end
    end
  end

  // Kernel bank shifts in whole words
  // Last word only carries w22 in its high byte
  always_ff @(posedge clk) begin
    if (wld_q) begin
      if (wlast_q) begin
        kernel <= {kernel[$bits(kernel)-9:0], wt_rd_data[15:8]};
      end else begin
        kernel <= {kernel[$bits(kernel)-17:0], wt_rd_data};
      end
    end
  end

  // ---------------------------------------------------------------------
  // Lane steps
  // ---------------------------------------------------------------------

  // Upper lane takes reads 0-5 and lower lane reads 2-7
  // Registered so each step meets its SRAM data
  always_ff @(posedge clk) begin
    if (rst) begin
      step_up     <= '0;
      step_lo     <= '0;
      blocks_done <= 1'b0;
    end else begin
      step_up     <= make_step(in_conv && (phase <= 3'd5), phase);
      step_lo     <= make_step(in_conv && (phase >= 3'd2), phase - 3'd2);
      blocks_done <= in_conv && (phase == 3'd7) && last_blk;
    end
  end

endmodule

// ==== verilog/conv_lane.sv ====
`timescale 1ns/1ps

module conv_lane (
  input  logic                clk,
  input  logic                rst,
  input  cnn_pkg::lane_step_s step,
  input  cnn_pkg::kernel_s    kernel,
  input  mem_pkg::in_word_u   in_rd_data,
  output cnn_pkg::lane_res_s  res
);

  // Pixel pair of the returned word
  cnn_pkg::pixel_t px_hi;
  cnn_pkg::pixel_t px_lo;

  // Kernel row for this step
  cnn_pkg::pixel_t k0;
  cnn_pkg::pixel_t k1;
  cnn_pkg::pixel_t k2;

  // Weights per output and byte
  cnn_pkg::pixel_t wl_hi;
  cnn_pkg::pixel_t wl_lo;
  cnn_pkg::pixel_t wr_hi;
  cnn_pkg::pixel_t wr_lo;

  logic signed [15:0] p_lh;
  logic signed [15:0] p_ll;
  logic signed [15:0] p_rh;
  logic signed [15:0] p_rl;

  cnn_pkg::acc_t sum_l;
  cnn_pkg::acc_t sum_r;
  cnn_pkg::acc_t acc_l;
  cnn_pkg::acc_t acc_r;
  cnn_pkg::acc_t acc_l_nxt;
  cnn_pkg::acc_t acc_r_nxt;

  // ReLU with saturation to a byte
  function automatic logic [7:0] relu_sat(input cnn_pkg::acc_t a);
    if (a < 0) begin
      return 8'd0;
    end else if (a > cnn_pkg::relu_max) begin
      return 8'(cnn_pkg::relu_max);
    end
    return a[7:0];
  endfunction

  assign px_hi = in_rd_data.pix.hi;
  assign px_lo = in_rd_data.pix.lo;

  always_comb begin
    case (step.krow)
      2'd0: begin
        k0 = kernel.w00;
        k1 = kernel.w01;
        k2 = kernel.w02;
      end
      2'd1: begin
        k0 = kernel.w10;
        k1 = kernel.w11;
        k2 = kernel.w12;
      end
      default: begin
        k0 = kernel.w20;
        k1 = kernel.w21;
        k2 = kernel.w22;
      end
    endcase
  end

  // Left output covers columns c..c+2
  // Left word gives c and c+1 and right word gives c+2
  assign wl_hi = step.half ? k2 : k0;
  assign wl_lo = step.half ? '0 : k1;

  // Right output covers c+1..c+3
  assign wr_hi = step.half ? k1 : '0;
  assign wr_lo = step.half ? k2 : k0;

  // Signed 8x8 products
  assign p_lh = px_hi * wl_hi;
  assign p_ll = px_lo * wl_lo;
  assign p_rh = px_hi * wr_hi;
  assign p_rl = px_lo * wr_lo;

  assign sum_l = cnn_pkg::acc_t'(p_lh) + cnn_pkg::acc_t'(p_ll);
  assign sum_r = cnn_pkg::acc_t'(p_rh) + cnn_pkg::acc_t'(p_rl);

  // First step loads instead of adding
  assign acc_l_nxt = step.first ? sum_l : acc_l + sum_l;
  assign acc_r_nxt = step.first ? sum_r : acc_r + sum_r;

  always_ff @(posedge clk) begin
    if (step.valid) begin
      acc_l <= acc_l_nxt;
      acc_r <= acc_r_nxt;
    end
  end

  // Result one cycle after the last step
  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= step.valid && step.last;
      if (step.valid && step.last) begin
        res.left  <= relu_sat(acc_l_nxt);
        res.right <= relu_sat(acc_r_nxt);
      end
    end
  end

endmodule

// ==== verilog/pool_pack.sv ====
`timescale 1ns/1ps

module pool_pack (
  input  logic               clk,
  input  logic               rst,
  input  cnn_pkg::lane_res_s res_up,
  input  cnn_pkg::lane_res_s res_lo,
  input  logic               blocks_done,
  output mem_pkg::out_wr_s   out_wr,
  output logic               done
);

  // Held upper pair
  logic [7:0] up_l;
  logic [7:0] up_r;

  logic [7:0] blk_max;
  logic [7:0] pool_val;
  logic [7:0] hi_byte;

  // Pool stage flags
  logic bd_q;
  logic pool_vld;
  logic pool_last;

  // Packing state
  logic           slot;
  mem_pkg::addr_t wr_addr;

  function automatic logic [7:0] max2(input logic [7:0] a, input logic [7:0] b);
    return (a > b) ? a : b;
  endfunction

  // Clamped bytes are never negative so plain compares work
  assign blk_max = max2(max2(up_l, up_r), max2(res_lo.left, res_lo.right));

  // ---------------------------------------------------------------------
  // 2x2 max
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (res_up.valid) begin
      up_l <= res_up.left;
      up_r <= res_up.right;
    end
    // Lower pair comes two cycles after the upper pair
    if (res_lo.valid) begin
      pool_val <= blk_max;
    end
  end

  // blocks_done comes with the last lower step
  // One lane cycle later it meets the last lower result
  always_ff @(posedge clk) begin
    if (rst) begin
      bd_q      <= 1'b0;
      pool_vld  <= 1'b0;
      pool_last <= 1'b0;
    end else begin
      bd_q      <= blocks_done;
      pool_vld  <= res_lo.valid;
      pool_last <= res_lo.valid && bd_q;
    end
  end

  // ---------------------------------------------------------------------
  // Byte packing and output writes
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_wr.en <= 1'b0;
      done      <= 1'b0;
      slot      <= 1'b0;
      wr_addr   <= '0;
    end else begin
      // Write when the low byte fills or on the final flush
      out_wr.en <= pool_vld && (slot || pool_last);
      done      <= pool_vld && pool_last;
      if (pool_vld) begin
        out_wr.addr <= wr_addr;
        if (slot) begin
          out_wr.data <= {hi_byte, pool_val};
        end else begin
          // Flush pads the low byte with zero
          out_wr.data <= {pool_val, 8'd0};
          hi_byte     <= pool_val;
        end
        if (pool_last) begin
          // Next job starts at address 0 again
          slot    <= 1'b0;
          wr_addr <= '0;
        end else begin
          slot <= !slot;
          if (slot) begin
            wr_addr <= wr_addr + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== verilog/conv_pool_top.sv ====
`timescale 1ns/1ps

module conv_pool_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             dut_run,
  output logic             dut_busy,
  output mem_pkg::addr_t   in_rd_addr,
  input  mem_pkg::data_t   in_rd_data,
  output mem_pkg::addr_t   wt_rd_addr,
  input  mem_pkg::data_t   wt_rd_data,
  output mem_pkg::out_wr_s out_wr
);

  // Controller to lanes
  cnn_pkg::kernel_s    kernel;
  cnn_pkg::lane_step_s step_up;
  cnn_pkg::lane_step_s step_lo;

  // Lanes to pooling
  cnn_pkg::lane_res_s  res_up;
  cnn_pkg::lane_res_s  res_lo;

  // End of job handshake between pooling and controller
  logic                blocks_done;
  logic                pool_done;

  conv_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .dut_run     (dut_run),
    .in_rd_data  (in_rd_data),
    .wt_rd_data  (wt_rd_data),
    .done        (pool_done),
    .in_rd_addr  (in_rd_addr),
    .wt_rd_addr  (wt_rd_addr),
    .kernel      (kernel),
    .step_up     (step_up),
    .step_lo     (step_lo),
    .blocks_done (blocks_done),
    .dut_busy    (dut_busy)
  );

  // Top two rows of each conv block
  conv_lane u_lane_up (
    .clk        (clk),
    .rst        (rst),
    .step       (step_up),
    .kernel     (kernel),
    .in_rd_data (in_rd_data),
    .res        (res_up)
  );

  // Bottom two rows
  conv_lane u_lane_lo (
    .clk        (clk),
    .rst        (rst),
    .step       (step_lo),
    .kernel     (kernel),
    .in_rd_data (in_rd_data),
    .res        (res_lo)
  );

  pool_pack u_pool (
    .clk         (clk),
    .rst         (rst),
    .res_up      (res_up),
    .res_lo      (res_lo),
    .blocks_done (blocks_done),
    .out_wr      (out_wr),
    .done        (pool_done)
  );

endmodule

// ==== sim/conv_pool_chk.sv ====
`timescale 1ns/1ps

module conv_pool_chk (
  input logic             clk,
  input logic             rst,
  input logic             dut_busy,
  input mem_pkg::out_wr_s out_wr
);

  // Address the next write of the job must use
  mem_pkg::addr_t next_addr;

  // Back to 0 whenever the engine is idle
  always_ff @(posedge clk) begin
    if (rst || !dut_busy) begin
      next_addr <= '0;
    end else if (out_wr.en) begin
      next_addr <= out_wr.addr + mem_pkg::addr_t'(1);
    end
  end

  // Output writes only inside a job
  a_wr_busy: assert property (@(posedge clk) disable iff (rst) out_wr.en |-> dut_busy)
    else $error("output write while dut_busy is low");

  // Writes start at 0 and step by one
  a_wr_addr: assert property (@(posedge clk) disable iff (rst)
    out_wr.en |-> (out_wr.addr == next_addr))
    else $error("output write address out of sequence");

  // Idle while reset is held
  a_rst_idle: assert property (@(posedge clk) rst |=> !dut_busy)
    else $error("dut_busy high during reset");

endmodule

// ==== sim/conv_pool_tb.sv ====
`timescale 1ns/1ps

module conv_pool_tb;

  // Weight and pixel modes of the case table
  localparam logic [1:0] w_center = 2'd0;
  localparam logic [1:0] w_minus1 = 2'd1;
  localparam logic [1:0] w_plus9  = 2'd2;
  localparam logic [1:0] w_random = 2'd3;
  localparam logic [1:0] p_ramp   = 2'd0;
  localparam logic [1:0] p_const  = 2'd1;
  localparam logic [1:0] p_random = 2'd2;

  localparam int num_cases = 6;
  localparam int mem_depth = 2 ** mem_pkg::addr_w;

  typedef struct packed {
    logic [7:0]  n;
    logic [1:0]  wmode;
    logic [1:0]  pmode;
    logic        rerun;
    logic [15:0] exp_words;
  } case_s;

  // N, weights, pixels, extra dut_run during the job, ceil(B/2)
  case_s cases [num_cases] = '{
    '{8'd6,  w_center, p_ramp,   1'b0, 16'd2},
    '{8'd8,  w_minus1, p_ramp,   1'b0, 16'd5},
    '{8'd6,  w_plus9,  p_const,  1'b0, 16'd2},
    '{8'd8,  w_center, p_random, 1'b1, 16'd5},
    '{8'd16, w_random, p_random, 1'b0, 16'd25},
    '{8'd4,  w_random, p_random, 1'b0, 16'd1}
  };

  logic             clk = 1'b0;
  logic             rst;
  logic             dut_run;
  logic             dut_busy;
  mem_pkg::addr_t   in_rd_addr;
  mem_pkg::data_t   in_rd_data;
  mem_pkg::addr_t   wt_rd_addr;
  mem_pkg::data_t   wt_rd_data;
  mem_pkg::out_wr_s out_wr;

  // SRAM contents and addresses latched for the next read
  mem_pkg::data_t in_mem [mem_depth];
  mem_pkg::data_t wt_mem [mem_depth];
  mem_pkg::addr_t in_a = '0;
  mem_pkg::addr_t wt_a = '0;

  // Reference model state
  logic signed [7:0] img [cnn_pkg::max_n][cnn_pkg::max_n];
  logic signed [7:0] wgt [9];
  int                conv_res [cnn_pkg::max_n][cnn_pkg::max_n];
  mem_pkg::data_t    exp_q [$];

  // Captured output writes of the current job
  mem_pkg::data_t wr_data_q [$];
  mem_pkg::addr_t wr_addr_q [$];

  integer seed = 86;
  int     errors = 0;
  int     case_errs = 0;
  int     passed = 0;
  int     falls = 0;
  int     cycles = 0;
  int     limit = 0;
  logic   busy_q = 1'b0;

  always #2 clk = ~clk;

  conv_pool_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .dut_run    (dut_run),
    .dut_busy   (dut_busy),
    .in_rd_addr (in_rd_addr),
    .in_rd_data (in_rd_data),
    .wt_rd_addr (wt_rd_addr),
    .wt_rd_data (wt_rd_data),
    .out_wr     (out_wr)
  );

  bind conv_pool_top conv_pool_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .dut_busy (dut_busy),
    .out_wr   (out_wr)
  );

  // -------------------------------------------------------------------
  // SRAM models and output capture
  // -------------------------------------------------------------------

  // Mid-cycle sampling of addresses, writes and busy edges
  always @(negedge clk) begin
    in_a = in_rd_addr;
    wt_a = wt_rd_addr;
    if (busy_q && !dut_busy) begin
      falls = falls + 1;
    end
    busy_q = dut_busy;
    if (out_wr.en) begin
      wr_addr_q.push_back(out_wr.addr);
      wr_data_q.push_back(out_wr.data);
    end
  end

  // Read data one cycle after the address
  always @(posedge clk) begin
    #1;
    in_rd_data = in_mem[in_a];
    wt_rd_data = wt_mem[wt_a];
  end

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: run went past %0d cycles without finishing", limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors    = errors + 1;
      case_errs = case_errs + 1;
    end
  endtask

  // -------------------------------------------------------------------
  // Stimulus and reference model
  // -------------------------------------------------------------------

  task automatic fill_memories(input case_s tc);
    int n;
    n = int'(tc.n);
    // Background differs at every address
    for (int a = 0; a < mem_depth; a++) begin
      in_mem[a] = 16'(a) ^ 16'hc3a5;
      wt_mem[a] = 16'(a) ^ 16'h3c5a;
    end
    for (int k = 0; k < 9; k++) begin
      case (tc.wmode)
        w_center: wgt[k] = (k == 4) ? 8'sd1 : 8'sd0;
        w_minus1: wgt[k] = -8'sd1;
        w_plus9:  wgt[k] = 8'sd9;
        default:  wgt[k] = 8'($random(seed));
      endcase
    end
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        case (tc.pmode)
          p_ramp:  img[r][c] = 8'(3 * r + c + 1);
          p_const: img[r][c] = 8'sd100;
          default: img[r][c] = 8'($random(seed));
        endcase
      end
    end
    // Header high byte is junk the DUT ignores
    in_mem[0] = {8'h7e, 8'(n)};
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c += 2) begin
        in_mem[1 + r * (n / 2) + c / 2] = {img[r][c], img[r][c + 1]};
      end
    end
    for (int k = 0; k < 4; k++) begin
      wt_mem[k] = {wgt[2 * k], wgt[2 * k + 1]};
    end
    wt_mem[4] = {wgt[8], 8'h5c};
  endtask

  // Valid 3x3 conv, ReLU clamp, 2x2 max, two bytes per word
  task automatic build_expected(input int n);
    int         acc;
    int         m;
    int         np;
    int         cnt;
    logic [7:0] pend;
    np   = (n - 2) / 2;
    cnt  = 0;
    pend = 8'h00;
    exp_q.delete();
    for (int i = 0; i < n - 2; i++) begin
      for (int j = 0; j < n - 2; j++) begin
        acc = 0;
        for (int ki = 0; ki < 3; ki++) begin
          for (int kj = 0; kj < 3; kj++) begin
            acc = acc + int'(wgt[ki * 3 + kj]) * int'(img[i + ki][j + kj]);
          end
        end
        conv_res[i][j] = (acc < 0) ? 0 : ((acc > 127) ? 127 : acc);
      end
    end
    for (int pr = 0; pr < np; pr++) begin
      for (int pc = 0; pc < np; pc++) begin
        m = conv_res[2 * pr][2 * pc];
        m = (conv_res[2 * pr][2 * pc + 1] > m) ? conv_res[2 * pr][2 * pc + 1] : m;
        m = (conv_res[2 * pr + 1][2 * pc] > m) ? conv_res[2 * pr + 1][2 * pc] : m;
        m = (conv_res[2 * pr + 1][2 * pc + 1] > m) ? conv_res[2 * pr + 1][2 * pc + 1] : m;
        if (cnt % 2 == 0) begin
          pend = 8'(m);
        end else begin
          exp_q.push_back({pend, 8'(m)});
        end
        cnt = cnt + 1;
      end
    end
    // Odd count leaves a zero low byte
    if (cnt % 2 == 1) begin
      exp_q.push_back({pend, 8'h00});
    end
  endtask

  // Start pulse, optional stray pulse mid-job, then wait for idle
  task automatic run_job(input logic rerun);
    @(posedge clk);
    #1 dut_run = 1'b1;
    @(posedge clk);
    #1 dut_run = 1'b0;
    if (rerun) begin
      repeat (10) @(posedge clk);
      #1 dut_run = 1'b1;
      @(posedge clk);
      #1 dut_run = 1'b0;
    end
    do begin
      @(negedge clk);
    end while (dut_busy);
    // Fall is logged on this same negedge
    #1;
  endtask

  // -------------------------------------------------------------------
  // Case loop
  // -------------------------------------------------------------------

  initial begin
    case_s tc;
    int    nb;
    rst        = 1'b1;
    dut_run    = 1'b0;
    in_rd_data = '0;
    wt_rd_data = '0;
    // Job length plus margin per case
    limit = 20;
    for (int i = 0; i < num_cases; i++) begin
      nb    = (int'(cases[i].n) - 2) / 2;
      limit = limit + 6 + 8 * nb * nb + 50;
    end
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;

    // Cases run back to back with no idle gap
    for (int i = 0; i < num_cases; i++) begin
      tc = cases[i];
      fill_memories(tc);
      build_expected(int'(tc.n));
      wr_addr_q.delete();
      wr_data_q.delete();
      falls     = 0;
      case_errs = 0;
      run_job(tc.rerun);
      if (tc.rerun) begin
        // Stray pulse must not start a second job
        repeat (8) @(negedge clk);
        check_val("dut_busy", 32'(dut_busy), 32'd0);
      end
      check_val("busy_falls", falls, 1);
      check_val("write_count", wr_data_q.size(), 32'(tc.exp_words));
      for (int k = 0; k < wr_data_q.size() && k < exp_q.size(); k++) begin
        check_val($sformatf("out_wr.addr[%0d]", k), 32'(wr_addr_q[k]), k);
        check_val($sformatf("out_wr.data[%0d]", k), 32'(wr_data_q[k]), 32'(exp_q[k]));
      end
      $display("case %0d: N=%0d, %0d words, %0d mismatches",
               i, tc.n, wr_data_q.size(), case_errs);
      if (case_errs == 0) begin
        passed = passed + 1;
      end
    end

    $display("%0d of %0d cases passed, %0d failed checks", passed, num_cases, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/mem_pkg.sv
verilog/cnn_pkg.sv
verilog/conv_ctrl.sv
verilog/conv_lane.sv
verilog/pool_pack.sv
verilog/conv_pool_top.sv
sim/conv_pool_chk.sv
sim/conv_pool_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module conv_pool_tb \
  -Mdir obj_dir -o conv_pool_sim &&
  ./obj_dir/conv_pool_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
  echo "PASS" || { echo "FAIL"; exit 1; }
